// File: src/fb_pkg.sv
package fb_pkg;

    // panel geometry
    localparam int unsigned PIXEL_WIDTH      = 16;
    localparam int unsigned PIXEL_HEIGHT     = 8;
    localparam int unsigned PIXEL_HALFHEIGHT = 4;
    localparam int unsigned BYTES_PER_PIXEL  = 2;

    // one lane per subpanel and colour byte
    localparam int unsigned LANES     = (PIXEL_HEIGHT / PIXEL_HALFHEIGHT) * BYTES_PER_PIXEL;
    // each lane holds one byte per pixel of one subpanel
    localparam int unsigned ROW_WORDS = PIXEL_WIDTH * PIXEL_HALFHEIGHT;
    localparam int unsigned FB_BYTES  = LANES * ROW_WORDS;

    // pixel colour byte
    typedef logic [7:0] byte_t;
    // subpanel bit above colour bit
    typedef logic [1:0] lane_idx_t;
    // address inside one lane
    typedef logic [5:0] row_addr_t;
    // all lanes side by side, lane 3 in the top byte
    typedef logic [31:0] scan_word_t;

    // axi4-lite fields
    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // one byte write from the axi front to the ram
    typedef struct packed {
        logic      valid;
        lane_idx_t lane_idx;
        row_addr_t row_addr;
        byte_t     data;
    } fb_wr_req_t;

    // one beat of the scan stream
    typedef struct packed {
        row_addr_t  row_addr;
        scan_word_t data;
    } scan_beat_t;

    // write front FSM
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_COMMIT,
        WR_RESP
    } fb_wr_state_t;

endpackage

// File: src/fb_axil_write.sv
`timescale 1ns/1ps

module fb_axil_write (
    input  logic                ClockA,
    input  logic                reset,
    input  logic                awvalid,
    output logic                awready,
    input  fb_pkg::axil_addr_t  awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  fb_pkg::axil_data_t  wdata,
    input  logic [3:0]          wstrb,
    output logic                bvalid,
    input  logic                bready,
    output fb_pkg::axil_resp_t  bresp,
    output fb_pkg::fb_wr_req_t  wr_req
);

    fb_pkg::fb_wr_state_t state;

    // byte index is the word address, one byte per 32-bit slot
    logic [7:0]          byte_idx;
    logic                in_range;
    logic                handshake;

    // payload latched at the handshake
    logic                wr_ok;
    fb_pkg::lane_idx_t   lane_q;
    fb_pkg::row_addr_t   row_q;
    fb_pkg::byte_t       data_q;

    assign byte_idx = awaddr[9:2];
    assign in_range = (awaddr < fb_pkg::axil_addr_t'(fb_pkg::FB_BYTES * 4));

    // address and data are only taken together, and only when idle
    assign awready   = (state == fb_pkg::WR_IDLE) && awvalid && wvalid;
    assign wready    = awready;
    assign handshake = awready;

    always_ff @(posedge ClockA) begin
        if (reset) begin
            state  <= fb_pkg::WR_IDLE;
            bvalid <= 1'b0;
        end else begin
            case (state)
                fb_pkg::WR_IDLE: begin
                    if (handshake) begin
                        state <= fb_pkg::WR_COMMIT;
                    end
                end
                fb_pkg::WR_COMMIT: begin
                    // ram registers the request in this cycle
                    state <= fb_pkg::WR_RESP;
                end
                fb_pkg::WR_RESP: begin
                    // one spare cycle lets the lane write land before bvalid
                    if (!bvalid) begin
                        bvalid <= 1'b1;
                    end else if (bready) begin
                        bvalid <= 1'b0;
                        state  <= fb_pkg::WR_IDLE;
                    end
                end
                default: begin
                    state <= fb_pkg::WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge ClockA) begin
        if (handshake) begin
            // subpanel is the top index bit, colour select the bottom one
            lane_q <= {byte_idx[7], byte_idx[0]};
            row_q  <= byte_idx[6:1];
            data_q <= wdata[7:0];
            // strobe low is still okay, just nothing written
            wr_ok  <= in_range && wstrb[0];
            bresp  <= in_range ? fb_pkg::RESP_OKAY : fb_pkg::RESP_SLVERR;
        end
    end

    // request is live only during the commit cycle
    assign wr_req.valid    = (state == fb_pkg::WR_COMMIT) && wr_ok;
    assign wr_req.lane_idx = lane_q;
    assign wr_req.row_addr = row_q;
    assign wr_req.data     = data_q;

    // response comes exactly three cycles after its handshake
    a_bvalid_after_hs: assert property (@(posedge ClockA) disable iff (reset)
        $rose(bvalid) |-> $past(handshake, 3));

endmodule

// File: src/fb_lane_ram.sv
`timescale 1ns/1ps

module fb_lane_ram (
    input  logic               ClockA,
    input  logic               reset,
    input  logic               we,
    input  fb_pkg::row_addr_t  wr_addr,
    input  fb_pkg::byte_t      wr_data,
    input  logic               rd_en,
    input  fb_pkg::row_addr_t  rd_addr,
    output fb_pkg::byte_t      rd_data
);

    fb_pkg::byte_t     mem [fb_pkg::ROW_WORDS];
    fb_pkg::row_addr_t rd_addr_q;

    // contents start blank and survive reset
    initial begin
        for (int i = 0; i < fb_pkg::ROW_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // write port
    always_ff @(posedge ClockA) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // first read stage, address register
    always_ff @(posedge ClockA) begin
        if (rd_en) begin
            rd_addr_q <= rd_addr;
        end
    end

    // second read stage, output register
    always_ff @(posedge ClockA) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr_q];
        end
    end

endmodule

// File: src/fb_banked_ram.sv
`timescale 1ns/1ps

module fb_banked_ram (
    input  logic                ClockA,
    input  logic                reset,
    input  fb_pkg::fb_wr_req_t  wr_req,
    input  logic                rd_en,
    input  fb_pkg::row_addr_t   rd_addr,
    output fb_pkg::scan_word_t  rd_data
);

    // one registered write enable per lane
    logic [fb_pkg::LANES-1:0] we_q;
    // shared write address and data, registered with the enables
    fb_pkg::row_addr_t        wr_addr_q;
    fb_pkg::byte_t            wr_data_q;

    always_ff @(posedge ClockA) begin
        wr_addr_q <= wr_req.row_addr;
        wr_data_q <= wr_req.data;
    end

    genvar i;
    generate
        for (i = 0; i < fb_pkg::LANES; i++) begin : g_lane
            logic we_lane_c;

            // lane decode, subpanel and colour bit pick the lane
            assign we_lane_c = wr_req.valid
                && (wr_req.lane_idx == fb_pkg::lane_idx_t'(i));

            always_ff @(posedge ClockA) begin
                if (reset) begin
                    we_q[i] <= 1'b0;
                end else begin
                    we_q[i] <= we_lane_c;
                end
            end

            // every lane reads the same row; outputs stack with lane 3 on top
            fb_lane_ram u_lane (
                .ClockA  (ClockA),
                .reset   (reset),
                .we      (we_q[i]),
                .wr_addr (wr_addr_q),
                .wr_data (wr_data_q),
                .rd_en   (rd_en),
                .rd_addr (rd_addr),
                .rd_data (rd_data[i*8 +: 8])
            );
        end
    endgenerate

    // write enables last one cycle per request
    a_one_lane_we: assert property (@(posedge ClockA) disable iff (reset)
        (|we_q) |=> (we_q == '0));

endmodule

// File: src/fb_scan_reader.sv
`timescale 1ns/1ps

module fb_scan_reader (
    input  logic                ClockA,
    input  logic                reset,
    output logic                rd_en,
    output fb_pkg::row_addr_t   rd_addr,
    input  fb_pkg::scan_word_t  rd_data,
    output logic                scan_valid,
    input  logic                scan_ready,
    output fb_pkg::scan_beat_t  scan_beat
);

    // next row to issue
    fb_pkg::row_addr_t row_cnt;

    // shadow of the ram address register
    logic              v1;
    fb_pkg::row_addr_t a1;
    // shadow of the ram output register
    logic              v2;
    fb_pkg::row_addr_t a2;

    // freeze everything while a beat waits
    assign rd_en   = !(v2 && !scan_ready);
    assign rd_addr = row_cnt;

    // row counter, wraps 63 to 0 by width
    always_ff @(posedge ClockA) begin
        if (reset) begin
            row_cnt <= '0;
        end else if (rd_en) begin
            row_cnt <= row_cnt + 1'b1;
        end
    end

    // valid bits step with the two ram read stages
    always_ff @(posedge ClockA) begin
        if (reset) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else if (rd_en) begin
            v1 <= 1'b1;
            v2 <= v1;
        end
    end

    // row numbers travel alongside the data
    always_ff @(posedge ClockA) begin
        if (rd_en) begin
            a1 <= row_cnt;
            a2 <= a1;
        end
    end

    assign scan_valid         = v2;
    assign scan_beat.row_addr = a2;
    // ram output register is the beat data
    assign scan_beat.data     = rd_data;

    // a stalled beat holds, data included, since the ram freezes too
    a_beat_hold: assert property (@(posedge ClockA) disable iff (reset)
        scan_valid && !scan_ready |=> scan_valid && $stable(scan_beat));

endmodule

// File: src/fb_subsystem_top.sv
`timescale 1ns/1ps

module fb_subsystem_top (
    input  logic                ClockA,
    input  logic                reset,
    // axi4-lite write channels
    input  logic                awvalid,
    output logic                awready,
    input  fb_pkg::axil_addr_t  awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  fb_pkg::axil_data_t  wdata,
    input  logic [3:0]          wstrb,
    output logic                bvalid,
    input  logic                bready,
    output fb_pkg::axil_resp_t  bresp,
    // scan stream to the panel shifter
    output logic                scan_valid,
    input  logic                scan_ready,
    output fb_pkg::scan_beat_t  scan_beat
);

    fb_pkg::fb_wr_req_t wr_req;
    logic               rd_en;
    fb_pkg::row_addr_t  rd_addr;
    fb_pkg::scan_word_t rd_data;

    // host write front
    fb_axil_write u_axil_write (
        .ClockA  (ClockA),
        .reset   (reset),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .wr_req  (wr_req)
    );

    // four byte lanes
    fb_banked_ram u_banked_ram (
        .ClockA  (ClockA),
        .reset   (reset),
        .wr_req  (wr_req),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // row scanner feeding the stream
    fb_scan_reader u_scan_reader (
        .ClockA     (ClockA),
        .reset      (reset),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .scan_valid (scan_valid),
        .scan_ready (scan_ready),
        .scan_beat  (scan_beat)
    );

endmodule

// File: sim/tb_fb_subsystem.sv
`timescale 1ns/1ps

module tb_fb_subsystem;

    localparam int RESET_CYCLES      = 8;
    localparam int MAX_OPS           = 32;
    localparam int ROWS              = 64;
    localparam logic [31:0] END_MARK = 32'hFFFF_FFFF;

    logic               ClockA;
    logic               reset;
    logic               awvalid;
    logic               awready;
    fb_pkg::axil_addr_t awaddr;
    logic               wvalid;
    logic               wready;
    fb_pkg::axil_data_t wdata;
    logic [3:0]         wstrb;
    logic               bvalid;
    logic               bready;
    fb_pkg::axil_resp_t bresp;
    logic               scan_valid;
    logic               scan_ready;
    fb_pkg::scan_beat_t scan_beat;

    // four words per stimulus line
    logic [31:0]   stim [4*MAX_OPS];
    // byte-index ordered copy of the framebuffer
    fb_pkg::byte_t model [fb_pkg::FB_BYTES];
    int            n_ops       = 0;
    bit            stim_loaded = 0;
    integer        seed        = 66834;
    // checked passes requested by the main sequence and finished by the monitor
    int            pass_target = 0;
    int            passes_done = 0;

    fb_subsystem_top uut (.*);

    initial begin : clock_gen
        ClockA = 1'b0;
        forever #10 ClockA = ~ClockA;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s expected 0x%0h actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    // only in-range writes with strobe bit 0 set reach the cell
    function automatic void apply_write(input fb_pkg::axil_addr_t addr,
                                        input fb_pkg::axil_data_t data,
                                        input logic [3:0] strb);
        if (addr < 12'd1024 && strb[0]) begin
            model[addr[9:2]] = data[7:0];
        end
    endfunction

    // lane l at row r holds byte index {l[1], r, l[0]}, lane 3 on top
    function automatic fb_pkg::scan_word_t expected_word(input fb_pkg::row_addr_t row);
        fb_pkg::scan_word_t word;
        for (int lane = 0; lane < fb_pkg::LANES; lane++) begin
            word[lane*8 +: 8] = model[{lane[1], row, lane[0]}];
        end
        return word;
    endfunction

    task automatic axi_write(input fb_pkg::axil_addr_t addr, input fb_pkg::axil_data_t data,
                             input logic [3:0] strb, output fb_pkg::axil_resp_t resp);
        @(posedge ClockA);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        @(negedge ClockA);
        // both readies rise and fall together
        check_value("wready with awready", awready, wready);
        while (!awready) begin
            @(negedge ClockA);
            check_value("wready with awready", awready, wready);
        end
        // handshake edge
        @(posedge ClockA);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        @(negedge ClockA);
        while (!bvalid) begin
            @(negedge ClockA);
        end
        resp = bresp;
        @(posedge ClockA);
        bready <= 1'b0;
    endtask

    task automatic run_check_passes(input int count);
        pass_target = pass_target + count;
        wait (passes_done == pass_target);
    endtask

    // random back-pressure, ready about three beats in four
    initial begin : ready_driver
        forever begin
            @(posedge ClockA);
            scan_ready <= ($random(seed) % 4) != 0;
        end
    end

    initial begin : stream_monitor
        fb_pkg::row_addr_t  next_row;
        fb_pkg::scan_beat_t held_beat;
        bit                 held;
        bit                 armed;
        bit                 checking;
        next_row = '0;
        held     = 1'b0;
        armed    = 1'b0;
        checking = 1'b0;
        @(posedge ClockA);
        forever begin
            @(negedge ClockA);
            if (reset) begin
                check_value("bvalid during reset", 0, bvalid);
                check_value("scan_valid during reset", 0, scan_valid);
            end else begin
                if (held) begin
                    check_value("stalled beat valid", 1, scan_valid);
                    check_value("stalled beat hold", held_beat, scan_beat);
                end
                if (scan_valid && scan_ready) begin
                    // first beat after reset must be row 0
                    check_value("row sequence", next_row, scan_beat.row_addr);
                    next_row = next_row + 1'b1;
                    if (!checking && armed && scan_beat.row_addr == 0) begin
                        checking = 1'b1;
                        armed    = 1'b0;
                    end
                    if (checking) begin
                        check_value($sformatf("beat data row %0d", scan_beat.row_addr),
                                    expected_word(scan_beat.row_addr), scan_beat.data);
                        if (scan_beat.row_addr == ROWS - 1) begin
                            checking    = 1'b0;
                            passes_done = passes_done + 1;
                            armed       = (passes_done < pass_target);
                        end
                    end else if (passes_done < pass_target && scan_beat.row_addr == ROWS - 1) begin
                        // row 63 taken after the request, so the next row 0 starts a fresh pass
                        armed = 1'b1;
                    end
                end
                held      = scan_valid && !scan_ready;
                held_beat = scan_beat;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (stim_loaded);
        // 20 cycles per write and four scan passes at four cycles a beat
        limit = n_ops * 20 + 4 * ROWS * 4;
        repeat (limit) @(posedge ClockA);
        abort_run($sformatf("timeout after %0d cycles with tests still running", limit));
    end

    initial begin : main_sequence
        fb_pkg::axil_addr_t op_addr;
        fb_pkg::axil_data_t op_data;
        logic [3:0]         op_strb;
        fb_pkg::axil_resp_t op_resp;
        fb_pkg::axil_resp_t rule_resp;
        fb_pkg::axil_resp_t got_resp;
        fb_pkg::byte_t      scan_wr_idx;
        fb_pkg::axil_data_t scan_wr_data;
        int                 scan_wr_delay;
        reset      = 1'b1;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        bready     = 1'b0;
        scan_ready = 1'b0;
        for (int i = 0; i < fb_pkg::FB_BYTES; i++) begin
            model[i] = '0;
        end
        $readmemh("sim/fb_stimulus.txt", stim);
        while (n_ops < MAX_OPS && stim[4*n_ops] !== END_MARK) begin
            n_ops = n_ops + 1;
        end
        if (n_ops == 0) begin
            abort_run("stimulus file holds no write operations");
        end
        stim_loaded = 1'b1;
        // values for the write issued while the scan streams
        scan_wr_idx   = fb_pkg::byte_t'($random(seed));
        scan_wr_data  = $random(seed);
        scan_wr_delay = $unsigned($random(seed)) % ROWS;

        repeat (RESET_CYCLES) @(posedge ClockA);
        reset <= 1'b0;
        @(negedge ClockA);
        check_value("bvalid after reset", 0, bvalid);
        check_value("scan_valid after reset", 0, scan_valid);

        // file writes, each response against the file and the address rule
        for (int i = 0; i < n_ops; i++) begin
            op_addr   = stim[4*i][11:0];
            op_data   = stim[4*i+1];
            op_strb   = stim[4*i+2][3:0];
            op_resp   = stim[4*i+3][1:0];
            rule_resp = (op_addr < 12'd1024) ? fb_pkg::RESP_OKAY : fb_pkg::RESP_SLVERR;
            check_value($sformatf("stimulus line %0d response code", i), rule_resp, op_resp);
            axi_write(op_addr, op_data, op_strb, got_resp);
            check_value($sformatf("bresp line %0d", i), op_resp, got_resp);
            apply_write(op_addr, op_data, op_strb);
        end
        // byte placement over one full pass
        run_check_passes(1);

        // new byte must differ from the cell so the later passes can see it
        if (scan_wr_data[7:0] == model[scan_wr_idx]) begin
            scan_wr_data[7:0] = ~model[scan_wr_idx];
        end

        // write while the stream runs, then two later passes must show it
        repeat (scan_wr_delay) @(posedge ClockA);
        op_addr = {2'b00, scan_wr_idx, 2'b00};
        axi_write(op_addr, scan_wr_data, 4'hF, got_resp);
        check_value("bresp write during scan", fb_pkg::RESP_OKAY, got_resp);
        apply_write(op_addr, scan_wr_data, 4'hF);
        run_check_passes(2);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: sim/fb_stimulus.txt
// columns: awaddr wdata wstrb expected_bresp (hex, 0 okay, 2 slverr)
// byte index is awaddr[9:2]; last line FFFFFFFF marks the end
000 000000A1 F 0
004 000000B2 F 0
200 000000C3 F 0
204 000000D4 F 0
1F8 0000005E 1 0
1FC 0000006F 1 0
3F8 12345678 F 0
3FC 9ABCDEF0 F 0
050 00000011 F 0
050 00000022 1 0
054 000000EE E 0
250 000000EE 2 0
400 000000FF F 2
7FC 000000FF F 2
FFC 000000FF F 2
0F0 00000033 F 0
0F4 00000044 F 0
2F0 00000055 F 0
2F4 00000066 F 0
104 00000077 F 0
300 00000088 F 0
104 000000AA 0 0
504 000000AA F 2
008 00000099 8 0
00C 0000FF01 1 0
208 00000002 F 0
20C 00000003 F 0
100 000000A5 F 0
304 0000005A F 0
3FF 00000042 F 0
180 000000C0 3 0
FFFFFFFF 00000000 0 0

// File: fb_subsystem.f
src/fb_pkg.sv
src/fb_axil_write.sv
src/fb_lane_ram.sv
src/fb_banked_ram.sv
src/fb_scan_reader.sv
src/fb_subsystem_top.sv
sim/tb_fb_subsystem.sv

// File: Bender.yml
package:
  name: fb_subsystem

dependencies: {}

sources:
  # package first, then the stages, then the top level
  - src/fb_pkg.sv
  - src/fb_axil_write.sv
  - src/fb_lane_ram.sv
  - src/fb_banked_ram.sv
  - src/fb_scan_reader.sv
  - src/fb_subsystem_top.sv

  # testbench, top module tb_fb_subsystem
  - target: test
    files:
      - sim/tb_fb_subsystem.sv
